//--- aggregator/aggregator.sv
`timescale 1ns/10ps
`default_nettype none

module aggregator import aggregator_pkg::*; (
	input  wire logic  clk,
	input  wire logic  reset,
	// Engine 1
	input  wire word_t data_in1,
	input  wire logic  valid_1,
	output logic       ready_1,
	// Engine 2
	input  wire word_t data_in2,
	input  wire logic  valid_2,
	output logic       ready_2,
	// Sink
	output word_t      data_out,
	output logic       valid,
	input  wire logic  ready
);

	// ----------------------------------------------------------
	// Internal nets
	// ----------------------------------------------------------

	// Strobe for a word taken from the selected engine
	logic        take;
	// Selected engine's data
	word_t       word;
	// Lanes of word that belong to the packet
	lane_count_t word_lanes;
	// Word closes the packet
	logic        last;

	// Engine selection, requests, drain wait
	aggregator_ctrl i_ctrl (
		.clk       (clk),
		.reset     (reset),
		.data_in1  (data_in1),
		.data_in2  (data_in2),
		.valid_1   (valid_1),
		.valid_2   (valid_2),
		.out_valid (valid),
		.last      (last),
		.ready_1   (ready_1),
		.ready_2   (ready_2),
		.take      (take),
		.word      (word)
	);

	// Header decode and per-packet lane count
	length_tracker i_length (
		.clk        (clk),
		.reset      (reset),
		.take       (take),
		.word       (word),
		.word_lanes (word_lanes),
		.last       (last)
	);

	// Dense packing into output words
	lane_packer i_packer (
		.clk        (clk),
		.reset      (reset),
		.take       (take),
		.word       (word),
		.word_lanes (word_lanes),
		.ready      (ready),
		.data_out   (data_out),
		.out_valid  (valid)
	);

endmodule

`default_nettype wire

//--- aggregator/aggregator_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module aggregator_ctrl import aggregator_pkg::*; (
	input  wire logic  clk,
	input  wire logic  reset,
	input  wire word_t data_in1,
	input  wire word_t data_in2,
	input  wire logic  valid_1,
	input  wire logic  valid_2,
	// Output word waiting at the sink
	input  wire logic  out_valid,
	// Current word ends the packet
	input  wire logic  last,
	output logic       ready_1,
	output logic       ready_2,
	output logic       take,
	output word_t      word
);

	agg_state_t state;
	agg_state_t next_state;

	// Engine owning the current packet
	// Zero selects engine 1
	logic sel;

	// ----------------------------------------------------------
	// Source side
	// ----------------------------------------------------------

	// Owner asked only while requesting and out of reset
	assign ready_1 = !reset && (state == ST_REQUEST) && !sel;
	assign ready_2 = !reset && (state == ST_REQUEST) && sel;

	// Word accepted on this edge
	assign take = (ready_1 && valid_1) || (ready_2 && valid_2);

	// Owner's data to the tracker and packer
	assign word = sel ? data_in2 : data_in1;

	// ----------------------------------------------------------
	// State machine
	// ----------------------------------------------------------

	always_comb begin
		next_state = state;
		case (state)
			ST_REQUEST: begin
				if (take) begin
					next_state = ST_SETTLE;
				end
			end
			// One quiet cycle so the packer result is visible
			ST_SETTLE: begin
				if (out_valid) begin
					next_state = ST_DRAIN;
				end else begin
					next_state = ST_REQUEST;
				end
			end
			// Hold off sources until the sink takes the word
			ST_DRAIN: begin
				if (!out_valid) begin
					next_state = ST_REQUEST;
				end
			end
			default: begin
				next_state = ST_REQUEST;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_REQUEST;
		end else begin
			state <= next_state;
		end
	end

	// Alternate engines at packet boundaries
	always_ff @(posedge clk) begin
		if (reset) begin
			sel <= 1'b0;
		end else if (take && last) begin
			sel <= !sel;
		end
	end

endmodule

`default_nettype wire

//--- aggregator/lane_packer.sv
`timescale 1ns/10ps
`default_nettype none

module lane_packer import aggregator_pkg::*; (
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic        take,
	input  wire word_t       word,
	input  wire lane_count_t word_lanes,
	// Sink ready
	input  wire logic        ready,
	output word_t            data_out,
	output logic             out_valid
);

	// ----------------------------------------------------------
	// Helpers and state
	// ----------------------------------------------------------

	// Ones over lanes 0 to n-1
	function automatic word_t lane_mask(input lane_count_t n);
		word_t mask;
		mask = '0;
		for (int i = 0; i < LANES; i++) begin
			if (i < n) begin
				mask[i*LANE_WIDTH +: LANE_WIDTH] = '1;
			end
		end
		return mask;
	endfunction

	// Lanes already placed in acc
	lane_count_t fill;
	word_t       acc;

	// Spill past lane 7, waits for the sink
	word_t       carry;
	lane_count_t carry_lanes;

	// Incoming lanes, shifted to the fill point
	word_t                   masked;
	logic [2*DATA_WIDTH-1:0] spread;
	word_t                   merged;
	lane_count_t             total;

	// ----------------------------------------------------------
	// Shift and merge
	// ----------------------------------------------------------

	always_comb begin
		// Drop lanes past the packet end
		masked = word & lane_mask(word_lanes);
		spread = {{DATA_WIDTH{1'b0}}, masked} << (fill * LANE_WIDTH);
		// Stale lanes above fill are cleared before OR
		merged = (acc & lane_mask(fill)) | spread[DATA_WIDTH-1:0];
		total = fill + word_lanes;
	end

	// Fill level and output flag
	always_ff @(posedge clk) begin
		if (reset) begin
			fill <= '0;
			carry_lanes <= '0;
			out_valid <= 1'b0;
		end else if (out_valid) begin
			// Restart from carry once the sink has the word
			if (ready) begin
				out_valid <= 1'b0;
				fill <= carry_lanes;
			end
		end else if (take) begin
			if (total >= lane_count_t'(LANES)) begin
				out_valid <= 1'b1;
				carry_lanes <= total - lane_count_t'(LANES);
			end else begin
				fill <= total;
			end
		end
	end

	// Payload registers
	always_ff @(posedge clk) begin
		if (out_valid) begin
			if (ready) begin
				acc <= carry;
			end
		end else if (take) begin
			if (total >= lane_count_t'(LANES)) begin
				data_out <= merged;
				carry <= spread[2*DATA_WIDTH-1:DATA_WIDTH];
			end else begin
				acc <= merged;
			end
		end
	end

endmodule

`default_nettype wire

//--- aggregator/length_tracker.sv
`timescale 1ns/10ps
`default_nettype none

module length_tracker import aggregator_pkg::*; (
	input  wire logic  clk,
	input  wire logic  reset,
	input  wire logic  take,
	input  wire word_t word,
	output lane_count_t word_lanes,
	output logic        last
);

	// Packet in progress, next word is payload
	logic        pkt_open;
	lane_total_t remaining;

	byte_len_t   header_len;
	// One extra bit so rounding cannot wrap
	logic [32:0] byte_total;
	lane_total_t header_lanes;
	// Lanes left counting this word
	lane_total_t pkt_lanes;

	always_comb begin
		// Header value in lane 0
		header_len = word[LANE_WIDTH-1:0];
		// Payload plus header, rounded up to whole lanes
		byte_total = 33'(header_len) + 33'(HEADER_BYTES) + 33'(LANE_WIDTH / 8 - 1);
		header_lanes = lane_total_t'(byte_total / 33'(LANE_WIDTH / 8));
		pkt_lanes = pkt_open ? remaining : header_lanes;
		// Full word unless the packet ends here
		if (pkt_lanes > lane_total_t'(LANES)) begin
			word_lanes = lane_count_t'(LANES);
			last = 1'b0;
		end else begin
			word_lanes = lane_count_t'(pkt_lanes);
			last = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pkt_open <= 1'b0;
		end else if (take) begin
			pkt_open <= !last;
		end
	end

	// Don't care once the packet closes
	always_ff @(posedge clk) begin
		if (take) begin
			remaining <= pkt_lanes - lane_total_t'(LANES);
		end
	end

endmodule

`default_nettype wire

//--- common/aggregator_pkg.sv
`default_nettype none

package aggregator_pkg;

	// ----------------------------------------------------------
	// Word geometry
	// ----------------------------------------------------------

	// One word of eight lanes, lane 0 in the low bits
	localparam int DATA_WIDTH = 256;
	localparam int LANE_WIDTH = 32;
	localparam int LANES = DATA_WIDTH / LANE_WIDTH;

	// Header lane carries the payload byte count
	localparam int HEADER_BYTES = 4;

	// ----------------------------------------------------------
	// Vector types
	// ----------------------------------------------------------

	typedef logic [DATA_WIDTH-1:0] word_t;

	// 0 to 8 lanes
	typedef logic [3:0] lane_count_t;

	typedef logic [31:0] byte_len_t;

	// Lanes left in the open packet
	typedef logic [30:0] lane_total_t;

	// Control FSM states
	typedef enum logic [1:0] {
		ST_REQUEST,
		ST_SETTLE,
		ST_DRAIN
	} agg_state_t;

endpackage

`default_nettype wire

//--- compile.f
common/aggregator_pkg.sv
aggregator/length_tracker.sv
aggregator/lane_packer.sv
aggregator/aggregator_ctrl.sv
aggregator/aggregator.sv
test/tb_aggregator_assert.sv
test/tb_aggregator.sv

//--- test/tb_aggregator.sv
`timescale 1ns/10ps
`default_nettype none

module tb_aggregator import aggregator_pkg::*; ();

	logic clk, reset, ready, valid, valid_1, valid_2, ready_1, ready_2;
	word_t data_in1, data_in2, data_out, held_word;

	// Engine word queues, last-word flags and model lane stream
	word_t q1[$], q2[$];
	bit l1[$], l2[$];
	logic [31:0] ref_lanes[$];

	logic [31:0] lfsr;
	int errors = 0, tests = 0, bad_tests = 0, pkt_count = 0;
	// Engine owning the open packet
	// Zero means engine 1
	bit owner = 1'b0;
	bit slow_sink = 1'b0;
	bit held = 1'b0;

	aggregator i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ----------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------

	// Fibonacci LFSR with taps 32 22 2 1
	// One step per random bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] got,
			input logic [DATA_WIDTH-1:0] exp);
		assert (got === exp) else begin
			$display("error %0t %s got %0h expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	// Random packet for the engine in turn
	// Its lanes also go to the model queue
	task automatic make_packet(input int lmin, input int lmax);
		int len;
		int lanes;
		word_t w;
		logic [31:0] lane;
		len = lmin + int'(rand_bits(7)) % (lmax - lmin + 1);
		lanes = (len + HEADER_BYTES + 3) / 4;
		for (int i = 0; i < lanes; i++) begin
			// Junk in lanes past the packet end
			if (i % LANES == 0) begin
				lane = rand_bits(32);
				w = {LANES{lane}};
			end
			lane = (i == 0) ? 32'(len) : rand_bits(32);
			ref_lanes.push_back(lane);
			w[(i % LANES)*LANE_WIDTH +: LANE_WIDTH] = lane;
			if (i % LANES == LANES - 1 || i == lanes - 1) begin
				if (pkt_count % 2 == 0) begin
					q1.push_back(w);
					l1.push_back(i == lanes - 1);
				end else begin
					q2.push_back(w);
					l2.push_back(i == lanes - 1);
				end
			end
		end
		pkt_count++;
	endtask

	// Sample on the rising edge and drive on the falling edge
	task automatic clock_cycle();
		word_t exp_word;
		bit took1;
		bit took2;
		@(posedge clk);
		took1 = ready_1 && valid_1;
		took2 = ready_2 && valid_2;
		assert (!(ready_1 && owner) && !(ready_2 && !owner)) else begin
			$display("engine asked while the other engine owns the packet at %0t", $time);
			errors++;
		end
		// Sources idle while a word waits at the sink
		if (valid) begin
			check_value("ready_1", ready_1, 0);
			check_value("ready_2", ready_2, 0);
		end
		if (held) begin
			check_value("valid", valid, 1);
			check_value("data_out", data_out, held_word);
		end
		if (valid && ready) begin
			assert (ref_lanes.size() >= LANES) else begin
				$display("output word beyond the model lane stream at %0t", $time);
				errors++;
			end
			for (int i = 0; i < LANES && ref_lanes.size() > 0; i++) begin
				exp_word[i*LANE_WIDTH +: LANE_WIDTH] = ref_lanes.pop_front();
			end
			check_value("data_out", data_out, exp_word);
		end
		held = valid && !ready;
		held_word = data_out;
		// Owner flips after a packet's last word
		if (took1) begin
			if (l1.pop_front()) owner = 1'b1;
			q1.delete(0);
		end
		if (took2) begin
			if (l2.pop_front()) owner = 1'b0;
			q2.delete(0);
		end
		@(negedge clk);
		valid_1 = valid_1 && !took1;
		valid_2 = valid_2 && !took2;
		// Random delay before the next word
		if (!valid_1 && q1.size() > 0 && rand_bits(1) == 1) begin
			valid_1 = 1'b1;
			data_in1 = q1[0];
		end
		if (!valid_2 && q2.size() > 0 && rand_bits(1) == 1) begin
			valid_2 = 1'b1;
			data_in2 = q2[0];
		end
		ready = slow_sink ? (rand_bits(3) == 0) : (rand_bits(2) != 0);
	endtask

	task automatic report_test(input string name, input int start_errors);
		tests++;
		if (errors != start_errors) begin
			bad_tests++;
		end
		$display("%-14s %0d errors", name, errors - start_errors);
	endtask

	task automatic run_phase(input string name, input int lmin, input int lmax,
			input int npkts, input bit slow);
		int start_errors;
		int cycles;
		start_errors = errors;
		slow_sink = slow;
		for (int i = 0; i < npkts; i++) begin
			make_packet(lmin, lmax);
		end
		// Until every full output word is out
		cycles = 0;
		while ((q1.size() > 0 || q2.size() > 0 || ref_lanes.size() >= LANES)
				&& cycles < 20000) begin
			clock_cycle();
			cycles++;
		end
		assert (cycles < 20000) else begin
			$display("%s timed out with words still pending", name);
			errors++;
		end
		report_test(name, start_errors);
	endtask

	// ----------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------

	initial begin
		lfsr = 32'h0322_d410;
		reset = 1'b1;
		ready = 1'b0;
		valid_1 = 1'b0;
		valid_2 = 1'b0;
		data_in1 = '0;
		data_in2 = '0;
		repeat (3) begin
			@(negedge clk);
			check_value("valid", valid, 0);
			check_value("ready_1", ready_1, 0);
			check_value("ready_2", ready_2, 0);
		end
		reset = 1'b0;
		@(negedge clk);
		// Engine 1 asked first
		check_value("ready_1", ready_1, 1);
		check_value("ready_2", ready_2, 0);
		check_value("valid", valid, 0);
		report_test("reset", 0);
		run_phase("single_word", 0, 28, 30, 1'b0);
		run_phase("multi_word", 33, 100, 16, 1'b0);
		run_phase("carry", 0, 100, 30, 1'b0);
		run_phase("back_pressure", 0, 100, 24, 1'b1);
		$display("%0d tests, %0d with errors, %0d errors", tests, bad_tests, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- test/tb_aggregator_assert.sv
`timescale 1ns/10ps
`default_nettype none

module tb_aggregator_assert import aggregator_pkg::*; (
	input wire logic  clk,
	input wire logic  reset,
	input wire logic  ready_1,
	input wire logic  ready_2,
	input wire logic  valid,
	input wire logic  ready,
	input wire word_t data_out
);

	// One engine asked at a time
	a_one_ready: assert property (@(posedge clk) disable iff (reset)
		!(ready_1 && ready_2))
		else $error("ready_1 and ready_2 high together");

	// Output word held until the sink takes it
	a_hold: assert property (@(posedge clk) disable iff (reset)
		valid && !ready |=> valid && $stable(data_out))
		else $error("output word changed before acceptance");

	// No source request under back-pressure
	a_no_request: assert property (@(posedge clk) disable iff (reset)
		valid && !ready |-> !ready_1 && !ready_2)
		else $error("engine ready high while an output word waits");

endmodule

bind aggregator tb_aggregator_assert i_assert (.*);

`default_nettype wire
